// File: logic/ahb_in_pkg.sv
// Shared types for the AHB input stage
// Transfer, burst, size and response encodings, beat offset width

`default_nettype none

package ahb_in_pkg;

  // Beat offset width, set by the 16-beat maximum burst
  localparam int OFFSET_W = 4;

  // HTRANS encoding
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,   // First beat or single
    SEQ    = 2'b11    // Follow-on beat
  } htrans_t;

  // HBURST encoding
  typedef enum logic [2:0] {
    SINGLE = 3'b000,
    INCR   = 3'b001,  // Undefined length
    WRAP4  = 3'b010,
    INCR4  = 3'b011,
    WRAP8  = 3'b100,
    INCR8  = 3'b101,
    WRAP16 = 3'b110,
    INCR16 = 3'b111
  } hburst_t;

  // HSIZE encoding, bytes per beat as a power of two
  typedef enum logic [2:0] {
    BYTE      = 3'b000,
    HALFWORD  = 3'b001,
    WORD      = 3'b010,
    DWORD     = 3'b011,
    SIZE_128  = 3'b100,
    SIZE_256  = 3'b101,
    SIZE_512  = 3'b110,
    SIZE_1024 = 3'b111
  } hsize_t;

  // HRESP encoding
  typedef enum logic [1:0] {
    OKAY  = 2'b00,
    ERROR = 2'b01,
    RETRY = 2'b10,    // Passed through only
    SPLIT = 2'b11     // Passed through only
  } hresp_t;

endpackage

`default_nettype wire

// File: logic/ahb_hold_capture.sv
// Address phase capture for the AHB input stage
// Valid address decode, load strobe and holding registers

`timescale 1ns/1ps
`default_nettype none

module ahb_hold_capture #(
  parameter int ADDR_W   = 32,
  parameter int MASTER_W = 4
) (
  input  wire                        HCLK,
  input  wire                        HRESETn,
  input  wire                        HSELS,        // Port select
  input  wire        [ADDR_W-1:0]    HADDRS,
  input  wire ahb_in_pkg::htrans_t   HTRANSS,
  input  wire                        HWRITES,
  input  wire ahb_in_pkg::hsize_t    HSIZES,
  input  wire ahb_in_pkg::hburst_t   HBURSTS,
  input  wire        [3:0]           HPROTS,
  input  wire        [MASTER_W-1:0]  HMASTERS,
  input  wire                        HMASTLOCKS,
  input  wire                        HREADYS,      // Previous transfer done
  output logic                       addr_valid,   // Active address phase
  output logic                       load_reg,     // Holding register load
  output ahb_in_pkg::htrans_t        held_trans,
  output logic       [ADDR_W-1:0]    held_addr,
  output logic                       held_write,
  output ahb_in_pkg::hsize_t         held_size,
  output ahb_in_pkg::hburst_t        held_burst,
  output logic       [3:0]           held_prot,
  output logic       [MASTER_W-1:0]  held_master,
  output logic                       held_mastlock
);

  import ahb_in_pkg::*;

  // ------------------------------------------------------------------
  // Address phase decode
  // ------------------------------------------------------------------

  // Selected and NONSEQ or SEQ, BUSY and IDLE need no response
  assign addr_valid = HSELS && (HTRANSS == NONSEQ || HTRANSS == SEQ);

  // Accepted only when the bus moves on
  assign load_reg = addr_valid && HREADYS;

  // ------------------------------------------------------------------
  // Holding registers
  // ------------------------------------------------------------------

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      held_trans    <= IDLE;
      held_addr     <= '0;
      held_write    <= 1'b0;
      held_size     <= BYTE;
      held_burst    <= SINGLE;
      held_prot     <= '0;
      held_master   <= '0;
      held_mastlock <= 1'b0;
    end
    else if (load_reg)
    begin
      // Whole address phase, in case output stage is busy
      held_trans    <= HTRANSS;
      held_addr     <= HADDRS;
      held_write    <= HWRITES;
      held_size     <= HSIZES;
      held_burst    <= HBURSTS;
      held_prot     <= HPROTS;
      held_master   <= HMASTERS;
      held_mastlock <= HMASTLOCKS;
    end
  end

  // Held type is always an active beat after a load
  a_load_active: assert property (@(posedge HCLK) disable iff (!HRESETn)
    load_reg |=> (held_trans == NONSEQ || held_trans == SEQ))
    else $error("holding register took an IDLE or BUSY phase");

endmodule

`default_nettype wire

// File: logic/ahb_pend_ctrl.sv
// Pending transfer control for the AHB input stage
// Pending flag, data phase valid flag, response mux towards the master

`timescale 1ns/1ps
`default_nettype none

module ahb_pend_ctrl (
  input  wire                       HCLK,
  input  wire                       HRESETn,
  input  wire                       HREADYS,
  input  wire                       addr_valid,
  input  wire                       load_reg,
  input  wire                       active_ip,     // Output stage serving this port
  input  wire                       readyout_ip,   // Shared slave HREADYOUT
  input  wire ahb_in_pkg::hresp_t   resp_ip,       // Shared slave HRESP
  output logic                      pend_reg,      // Held copy in use
  output logic                      held_tran_ip,  // Request to arbiter
  output logic                      HREADYOUTS,
  output ahb_in_pkg::hresp_t        HRESPS
);

  import ahb_in_pkg::*;

  logic pend_next;    // Next pending state
  logic data_valid;   // Data phase of a valid transfer

  // ------------------------------------------------------------------
  // Pending transfer
  // ------------------------------------------------------------------

  // New load while output stage elsewhere wins over the drain
  assign pend_next = (load_reg && !active_ip) ? 1'b1 :
                     (active_ip && readyout_ip) ? 1'b0 :
                     pend_reg;

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      pend_reg <= 1'b0;
    else
      pend_reg <= pend_next;
  end

  // Live in load cycle, kept up until drained
  assign held_tran_ip = load_reg || pend_reg;

  // Data phase tracks address phase on each accepted beat
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      data_valid <= 1'b0;
    else if (HREADYS)
      data_valid <= addr_valid;
  end

  // ------------------------------------------------------------------
  // Response to master
  // ------------------------------------------------------------------

  always_comb
  begin
    if (!data_valid)
    begin
      HREADYOUTS = 1'b1;          // Idle, busy or unselected
      HRESPS     = OKAY;
    end
    else if (pend_reg)
    begin
      HREADYOUTS = 1'b0;          // Wait until held copy drains
      HRESPS     = OKAY;
    end
    else
    begin
      HREADYOUTS = readyout_ip;   // Slave response straight through
      HRESPS     = resp_ip;
    end
  end

  // Pending only ever starts from a load the output stage missed
  a_pend_from_load: assert property (@(posedge HCLK) disable iff (!HRESETn)
    $rose(pend_reg) |-> $past(load_reg && !active_ip))
    else $error("pending flag set without a missed load");

endmodule

`default_nettype wire

// File: logic/ahb_wrap_bound.sv
// Wrap boundary tracker for the AHB input stage
// Flags a beat sitting at the last offset of a wrapping burst

`timescale 1ns/1ps
`default_nettype none

module ahb_wrap_bound #(
  parameter int ADDR_W = 32
) (
  input  wire                        HCLK,
  input  wire                        HRESETn,
  input  wire        [ADDR_W-1:0]    HADDRS,
  input  wire ahb_in_pkg::hsize_t    HSIZES,
  input  wire ahb_in_pkg::hburst_t   HBURSTS,
  input  wire ahb_in_pkg::htrans_t   HTRANSS,
  input  wire                        HREADYS,
  output logic                       bound      // Last beat before wrap
);

  import ahb_in_pkg::*;

  logic [OFFSET_W-1:0] offset;      // Beat number within aligned block
  logic [OFFSET_W-1:0] check;       // Offset with non-wrap bits forced
  logic                bound_next;
  logic                bound_en;

  // ------------------------------------------------------------------
  // Beat offset from address and size
  // ------------------------------------------------------------------

  always_comb
  begin
    case (HSIZES)
      BYTE:     offset = HADDRS[3:0];
      HALFWORD: offset = HADDRS[4:1];
      WORD:     offset = HADDRS[5:2];
      DWORD:    offset = HADDRS[6:3];
      default:  offset = HADDRS[3:0];   // 128 bits and up use byte offset
    endcase
  end

  // Upper bits forced high so only wrap bits decide
  always_comb
  begin
    case (HBURSTS)
      WRAP4:   check = {2'b11, offset[1:0]};
      WRAP8:   check = {1'b1, offset[2:0]};
      WRAP16:  check = offset;
      default: check = '0;              // Never a boundary
    endcase
  end

  assign bound_next = &check;

  // Only accepted NONSEQ or SEQ beats move the flag
  assign bound_en = (HTRANSS == NONSEQ || HTRANSS == SEQ) && HREADYS;

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      bound <= 1'b0;
    else if (bound_en)
      bound <= bound_next;
  end

endmodule

`default_nettype wire

// File: logic/ahb_burst_fixup.sv
// Output select and burst fix-up for the AHB input stage
// Held or direct transfer mux, override register, HTRANS and HBURST rewrite

`timescale 1ns/1ps
`default_nettype none

module ahb_burst_fixup #(
  parameter int ADDR_W   = 32,
  parameter int MASTER_W = 4
) (
  input  wire                        HCLK,
  input  wire                        HRESETn,
  input  wire                        HREADYS,
  input  wire                        active_ip,
  input  wire                        load_reg,
  input  wire                        pend_reg,
  input  wire                        bound,
  // Direct master side
  input  wire                        HSELS,
  input  wire        [ADDR_W-1:0]    HADDRS,
  input  wire ahb_in_pkg::htrans_t   HTRANSS,
  input  wire                        HWRITES,
  input  wire ahb_in_pkg::hsize_t    HSIZES,
  input  wire ahb_in_pkg::hburst_t   HBURSTS,
  input  wire        [3:0]           HPROTS,
  input  wire        [MASTER_W-1:0]  HMASTERS,
  input  wire                        HMASTLOCKS,
  // Holding registers
  input  wire ahb_in_pkg::htrans_t   held_trans,
  input  wire        [ADDR_W-1:0]    held_addr,
  input  wire                        held_write,
  input  wire ahb_in_pkg::hsize_t    held_size,
  input  wire ahb_in_pkg::hburst_t   held_burst,
  input  wire        [3:0]           held_prot,
  input  wire        [MASTER_W-1:0]  held_master,
  input  wire                        held_mastlock,
  // Towards output stage
  output logic                       sel_ip,
  output logic       [ADDR_W-1:0]    addr_ip,
  output ahb_in_pkg::htrans_t        trans_ip,
  output logic                       write_ip,
  output ahb_in_pkg::hsize_t         size_ip,
  output ahb_in_pkg::hburst_t        burst_ip,
  output logic       [3:0]           prot_ip,
  output logic       [MASTER_W-1:0]  master_ip,
  output logic                       mastlock_ip
);

  import ahb_in_pkg::*;

  htrans_t trans_int;       // Selected HTRANS before rewrite
  htrans_t trans_burst;     // Type that decides the burst rewrite
  hburst_t burst_int;       // Selected HBURST before rewrite
  logic    override;        // Interrupted burst being completed
  logic    override_next;

  // ------------------------------------------------------------------
  // Held or direct select
  // ------------------------------------------------------------------

  always_comb
  begin
    if (pend_reg)
    begin
      sel_ip      = 1'b1;
      trans_int   = NONSEQ;     // Held copy restarts the burst
      trans_burst = held_trans;
      addr_ip     = held_addr;
      write_ip    = held_write;
      size_ip     = held_size;
      burst_int   = held_burst;
      prot_ip     = held_prot;
      master_ip   = held_master;
      mastlock_ip = held_mastlock;
    end
    else
    begin
      sel_ip      = HSELS;
      trans_int   = HTRANSS;
      trans_burst = HTRANSS;
      addr_ip     = HADDRS;
      write_ip    = HWRITES;
      size_ip     = HSIZES;
      burst_int   = HBURSTS;
      prot_ip     = HPROTS;
      master_ip   = HMASTERS;
      mastlock_ip = HMASTLOCKS;
    end
  end

  // ------------------------------------------------------------------
  // Early burst termination
  // ------------------------------------------------------------------

  always_comb
  begin
    if (HTRANSS == NONSEQ || HTRANSS == IDLE)
      override_next = 1'b0;                  // Burst over
    else if (HTRANSS == SEQ && load_reg && !active_ip)
      override_next = 1'b1;                  // Burst broken mid-way
    else
      override_next = override;
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      override <= 1'b0;
    else if (HREADYS)
      override <= override_next;
  end

  // Remaining beats carry on as INCR
  assign burst_ip = (override && trans_burst != NONSEQ) ? INCR : burst_int;

  // Past a wrap edge SEQ becomes NONSEQ and BUSY becomes IDLE
  assign trans_ip = (override && bound) ? htrans_t'({trans_int[1], 1'b0}) : trans_int;

  // Override only starts on a SEQ beat the output stage missed
  a_override_start: assert property (@(posedge HCLK) disable iff (!HRESETn)
    $rose(override) |-> $past(HTRANSS == SEQ && load_reg && !active_ip && HREADYS))
    else $error("burst override set without an interrupted SEQ beat");

endmodule

`default_nettype wire

// File: logic/ahb_input_stage.sv
// AHB bus matrix input stage, top level
// Capture, pending control, burst fix-up and wrap boundary tracker

`timescale 1ns/1ps
`default_nettype none

module ahb_input_stage #(
  parameter int ADDR_W   = 32,    // At least 7 for the offset decode
  parameter int MASTER_W = 4
) (
  input  wire                        HCLK,
  input  wire                        HRESETn,
  // Master address phase
  input  wire                        HSELS,
  input  wire        [ADDR_W-1:0]    HADDRS,
  input  wire ahb_in_pkg::htrans_t   HTRANSS,
  input  wire                        HWRITES,
  input  wire ahb_in_pkg::hsize_t    HSIZES,
  input  wire ahb_in_pkg::hburst_t   HBURSTS,
  input  wire        [3:0]           HPROTS,
  input  wire        [MASTER_W-1:0]  HMASTERS,
  input  wire                        HMASTLOCKS,
  input  wire                        HREADYS,
  // Output stage status
  input  wire                        active_ip,
  input  wire                        readyout_ip,
  input  wire ahb_in_pkg::hresp_t    resp_ip,
  // Response to master
  output logic                       HREADYOUTS,
  output ahb_in_pkg::hresp_t         HRESPS,
  // Towards output stage
  output logic                       sel_ip,
  output logic       [ADDR_W-1:0]    addr_ip,
  output ahb_in_pkg::htrans_t        trans_ip,
  output logic                       write_ip,
  output ahb_in_pkg::hsize_t         size_ip,
  output ahb_in_pkg::hburst_t        burst_ip,
  output logic       [3:0]           prot_ip,
  output logic       [MASTER_W-1:0]  master_ip,
  output logic                       mastlock_ip,
  output logic                       held_tran_ip
);

  import ahb_in_pkg::*;

  logic                addr_valid;
  logic                load_reg;
  logic                pend_reg;
  logic                bound;
  htrans_t             held_trans;
  logic [ADDR_W-1:0]   held_addr;
  logic                held_write;
  hsize_t              held_size;
  hburst_t             held_burst;
  logic [3:0]          held_prot;
  logic [MASTER_W-1:0] held_master;
  logic                held_mastlock;

  // ------------------------------------------------------------------
  // Stage instances
  // ------------------------------------------------------------------

  ahb_hold_capture #(.ADDR_W(ADDR_W), .MASTER_W(MASTER_W)) u_capture (
    .HCLK, .HRESETn, .HSELS, .HADDRS, .HTRANSS, .HWRITES, .HSIZES,
    .HBURSTS, .HPROTS, .HMASTERS, .HMASTLOCKS, .HREADYS,
    .addr_valid, .load_reg,
    .held_trans, .held_addr, .held_write, .held_size, .held_burst,
    .held_prot, .held_master, .held_mastlock
  );

  ahb_pend_ctrl u_pend (
    .HCLK, .HRESETn, .HREADYS, .addr_valid, .load_reg,
    .active_ip, .readyout_ip, .resp_ip,
    .pend_reg, .held_tran_ip, .HREADYOUTS, .HRESPS
  );

  // Runs beside the chain on the direct inputs
  ahb_wrap_bound #(.ADDR_W(ADDR_W)) u_bound (
    .HCLK, .HRESETn, .HADDRS, .HSIZES, .HBURSTS, .HTRANSS, .HREADYS,
    .bound
  );

  ahb_burst_fixup #(.ADDR_W(ADDR_W), .MASTER_W(MASTER_W)) u_fixup (
    .HCLK, .HRESETn, .HREADYS, .active_ip, .load_reg, .pend_reg, .bound,
    .HSELS, .HADDRS, .HTRANSS, .HWRITES, .HSIZES, .HBURSTS, .HPROTS,
    .HMASTERS, .HMASTLOCKS,
    .held_trans, .held_addr, .held_write, .held_size, .held_burst,
    .held_prot, .held_master, .held_mastlock,
    .sel_ip, .addr_ip, .trans_ip, .write_ip, .size_ip, .burst_ip,
    .prot_ip, .master_ip, .mastlock_ip
  );

endmodule

`default_nettype wire

// File: verif/tb_ahb_input_stage.sv
// Testbench for the AHB input stage
// Table of per-cycle stimulus and expected outputs, checker, timeout

`timescale 1ns/1ps
`default_nettype none

module tb_ahb_input_stage;

  import ahb_in_pkg::*;

  localparam int ADDR_W   = 32;
  localparam int MASTER_W = 4;
  localparam int N_ROWS   = 34;
  localparam int TIMEOUT  = N_ROWS + 20;   // Cycle limit for the whole run

  logic                HCLK;
  logic                HRESETn;
  logic                HSELS;
  logic [ADDR_W-1:0]   HADDRS;
  htrans_t             HTRANSS;
  logic                HWRITES;
  hsize_t              HSIZES;
  hburst_t             HBURSTS;
  logic [3:0]          HPROTS;
  logic [MASTER_W-1:0] HMASTERS;
  logic                HMASTLOCKS;
  logic                HREADYS;
  logic                active_ip;
  logic                readyout_ip;
  hresp_t              resp_ip;
  logic                HREADYOUTS;
  hresp_t              HRESPS;
  logic                sel_ip;
  logic [ADDR_W-1:0]   addr_ip;
  htrans_t             trans_ip;
  logic                write_ip;
  hsize_t              size_ip;
  hburst_t             burst_ip;
  logic [3:0]          prot_ip;
  logic [MASTER_W-1:0] master_ip;
  logic                mastlock_ip;
  logic                held_tran_ip;

  // Stimulus columns
  string      t_name  [N_ROWS];
  logic       t_sel   [N_ROWS];
  logic [7:0] t_addr  [N_ROWS];   // Low address byte, upper bits random
  logic [1:0] t_trans [N_ROWS];
  logic [2:0] t_size  [N_ROWS];
  logic [2:0] t_burst [N_ROWS];
  logic       t_rdy   [N_ROWS];
  logic       t_act   [N_ROWS];
  logic       t_ro    [N_ROWS];
  logic [1:0] t_resp  [N_ROWS];
  // Expected columns
  logic       x_ready [N_ROWS];
  logic [1:0] x_resp  [N_ROWS];
  logic       x_held  [N_ROWS];
  logic       x_sel   [N_ROWS];
  logic [1:0] x_trans [N_ROWS];
  logic [2:0] x_burst [N_ROWS];
  logic [7:0] x_addr  [N_ROWS];

  // Random fields as driven on each row
  logic [ADDR_W-1:0]   a_addr   [N_ROWS];
  logic [3:0]          a_prot   [N_ROWS];
  logic [MASTER_W-1:0] a_master [N_ROWS];
  logic                a_write  [N_ROWS];
  logic                a_lock   [N_ROWS];

  int          n_rows    = 0;
  int          row;
  int          last_load = 0;   // Row of the latest accepted address phase
  int          cycle_cnt = 0;
  integer      seed;
  logic [31:0] rnd;

  ahb_input_stage #(.ADDR_W(ADDR_W), .MASTER_W(MASTER_W)) u_dut (
    .HCLK, .HRESETn, .HSELS, .HADDRS, .HTRANSS, .HWRITES, .HSIZES,
    .HBURSTS, .HPROTS, .HMASTERS, .HMASTLOCKS, .HREADYS,
    .active_ip, .readyout_ip, .resp_ip,
    .HREADYOUTS, .HRESPS,
    .sel_ip, .addr_ip, .trans_ip, .write_ip, .size_ip, .burst_ip,
    .prot_ip, .master_ip, .mastlock_ip, .held_tran_ip
  );

  // ------------------------------------------------------------------
  // Clock and run limit
  // ------------------------------------------------------------------

  initial HCLK = 1'b0;
  always #4 HCLK = ~HCLK;   // 8 ns period

  always @(posedge HCLK)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT)
    begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
      $display("Test FAILED");
      $fatal(1, "Timeout");
    end
  end

  // ------------------------------------------------------------------
  // Table helpers
  // ------------------------------------------------------------------

  task automatic add_row(input string name, input logic sel, input logic [7:0] addr,
                         input logic [1:0] trans, input logic [2:0] size,
                         input logic [2:0] burst, input logic rdy, input logic act,
                         input logic ro, input logic [1:0] resp,
                         input logic e_ready, input logic [1:0] e_resp,
                         input logic e_held, input logic e_sel, input logic [1:0] e_trans,
                         input logic [2:0] e_burst, input logic [7:0] e_addr);
    t_name[n_rows]  = name;
    t_sel[n_rows]   = sel;
    t_addr[n_rows]  = addr;
    t_trans[n_rows] = trans;
    t_size[n_rows]  = size;
    t_burst[n_rows] = burst;
    t_rdy[n_rows]   = rdy;
    t_act[n_rows]   = act;
    t_ro[n_rows]    = ro;
    t_resp[n_rows]  = resp;
    x_ready[n_rows] = e_ready;
    x_resp[n_rows]  = e_resp;
    x_held[n_rows]  = e_held;
    x_sel[n_rows]   = e_sel;
    x_trans[n_rows] = e_trans;
    x_burst[n_rows] = e_burst;
    x_addr[n_rows]  = e_addr;
    n_rows++;
  endtask

  // One cycle of stimulus, called right at the rising edge
  task automatic apply_row(input int i);
    rnd = $random(seed);
    a_addr[i]   = {rnd[ADDR_W-1:8], t_addr[i]};
    rnd = $random(seed);
    a_prot[i]   = rnd[3:0];
    a_master[i] = rnd[MASTER_W+3:4];
    a_write[i]  = rnd[8];
    a_lock[i]   = rnd[9];
    HADDRS      <= a_addr[i];
    HPROTS      <= a_prot[i];
    HMASTERS    <= a_master[i];
    HWRITES     <= a_write[i];
    HMASTLOCKS  <= a_lock[i];
    HSELS       <= t_sel[i];
    HTRANSS     <= htrans_t'(t_trans[i]);
    HSIZES      <= hsize_t'(t_size[i]);
    HBURSTS     <= hburst_t'(t_burst[i]);
    HREADYS     <= t_rdy[i];
    active_ip   <= t_act[i];
    readyout_ip <= t_ro[i];
    resp_ip     <= hresp_t'(t_resp[i]);
  endtask

  task automatic check_val(input string test, input string field,
                           input logic [31:0] exp_v, input logic [31:0] act_v);
    assert (act_v === exp_v)
    else
    begin
      $display("FAILED %s %s expected %0h actual %0h", test, field, exp_v, act_v);
      $display("Test FAILED");
      $fatal(1, "Output mismatch");
    end
  endtask

  task automatic check_row(input int i);
    int src;
    // Held rows expect another address than the one driven
    src = (x_addr[i] != t_addr[i]) ? last_load : i;
    check_val(t_name[i], "HREADYOUTS", x_ready[i], HREADYOUTS);
    check_val(t_name[i], "HRESPS", x_resp[i], HRESPS);
    check_val(t_name[i], "held_tran_ip", x_held[i], held_tran_ip);
    check_val(t_name[i], "sel_ip", x_sel[i], sel_ip);
    check_val(t_name[i], "trans_ip", x_trans[i], trans_ip);
    check_val(t_name[i], "burst_ip", x_burst[i], burst_ip);
    check_val(t_name[i], "addr_ip[7:0]", x_addr[i], addr_ip[7:0]);
    check_val(t_name[i], "addr_ip", a_addr[src], addr_ip);
    check_val(t_name[i], "size_ip", t_size[src], size_ip);
    check_val(t_name[i], "write_ip", a_write[src], write_ip);
    check_val(t_name[i], "prot_ip", a_prot[src], prot_ip);
    check_val(t_name[i], "master_ip", a_master[src], master_ip);
    check_val(t_name[i], "mastlock_ip", a_lock[src], mastlock_ip);
  endtask

  // ------------------------------------------------------------------
  // Stimulus table and main sequence
  // ------------------------------------------------------------------

  initial
  begin
    seed        = 32'hd1a3;
    HRESETn     = 1'b0;
    HSELS       = 1'b0;
    HADDRS      = '0;
    HTRANSS     = IDLE;
    HWRITES     = 1'b0;
    HSIZES      = WORD;
    HBURSTS     = SINGLE;
    HPROTS      = '0;
    HMASTERS    = '0;
    HMASTLOCKS  = 1'b0;
    HREADYS     = 1'b1;
    active_ip   = 1'b0;
    readyout_ip = 1'b1;
    resp_ip     = OKAY;

    // Stimulus: sel addr trans size burst rdy act ro resp
    // Expected: ready resp held sel trans burst addr
    add_row("reset_idle", 0, 8'h00, IDLE, WORD, SINGLE, 1, 1, 1, OKAY,
            1, OKAY, 0, 0, IDLE, SINGLE, 8'h00);
    add_row("pass_ns_read", 1, 8'h40, NONSEQ, WORD, SINGLE, 1, 1, 1, OKAY,
            1, OKAY, 1, 1, NONSEQ, SINGLE, 8'h40);
    add_row("pass_err_wait", 1, 8'h44, NONSEQ, WORD, SINGLE, 0, 1, 0, ERROR,
            0, ERROR, 0, 1, NONSEQ, SINGLE, 8'h44);
    add_row("pass_err_done", 1, 8'h44, IDLE, WORD, SINGLE, 1, 1, 1, ERROR,
            1, ERROR, 0, 1, IDLE, SINGLE, 8'h44);
    add_row("pass_after_idle", 0, 8'h48, NONSEQ, WORD, SINGLE, 1, 1, 1, ERROR,
            1, OKAY, 0, 0, NONSEQ, SINGLE, 8'h48);
    add_row("pass_after_unsel", 0, 8'h00, IDLE, WORD, SINGLE, 1, 0, 0, ERROR,
            1, OKAY, 0, 0, IDLE, SINGLE, 8'h00);
    // Hold and drain
    add_row("hold_load", 1, 8'h80, NONSEQ, WORD, SINGLE, 1, 0, 0, OKAY,
            1, OKAY, 1, 1, NONSEQ, SINGLE, 8'h80);
    add_row("hold_wait", 1, 8'h84, NONSEQ, WORD, SINGLE, 0, 0, 1, OKAY,
            0, OKAY, 1, 1, NONSEQ, SINGLE, 8'h80);
    add_row("hold_granted", 1, 8'h84, NONSEQ, WORD, SINGLE, 0, 1, 0, OKAY,
            0, OKAY, 1, 1, NONSEQ, SINGLE, 8'h80);
    add_row("hold_drain", 1, 8'h84, NONSEQ, WORD, SINGLE, 0, 1, 1, OKAY,
            0, OKAY, 1, 1, NONSEQ, SINGLE, 8'h80);
    add_row("hold_released", 1, 8'h84, NONSEQ, WORD, SINGLE, 1, 1, 1, OKAY,
            1, OKAY, 1, 1, NONSEQ, SINGLE, 8'h84);
    add_row("hold_idle", 1, 8'h00, IDLE, WORD, SINGLE, 1, 1, 1, OKAY,
            1, OKAY, 0, 1, IDLE, SINGLE, 8'h00);
    // INCR4 broken on second beat
    add_row("incr4_first", 1, 8'hC0, NONSEQ, WORD, INCR4, 1, 1, 1, OKAY,
            1, OKAY, 1, 1, NONSEQ, INCR4, 8'hC0);
    add_row("incr4_seq_held", 1, 8'hC4, SEQ, WORD, INCR4, 1, 0, 1, OKAY,
            1, OKAY, 1, 1, SEQ, INCR4, 8'hC4);
    add_row("incr4_held_out", 1, 8'hC8, SEQ, WORD, INCR4, 0, 0, 0, OKAY,
            0, OKAY, 1, 1, NONSEQ, INCR, 8'hC4);
    add_row("incr4_drain", 1, 8'hC8, SEQ, WORD, INCR4, 0, 1, 1, OKAY,
            0, OKAY, 1, 1, NONSEQ, INCR, 8'hC4);
    add_row("incr4_seq_incr", 1, 8'hC8, SEQ, WORD, INCR4, 1, 1, 1, OKAY,
            1, OKAY, 1, 1, SEQ, INCR, 8'hC8);
    add_row("incr4_seq_last", 1, 8'hCC, SEQ, WORD, INCR4, 1, 1, 1, OKAY,
            1, OKAY, 1, 1, SEQ, INCR, 8'hCC);
    add_row("incr4_new_ns", 1, 8'h10, NONSEQ, WORD, INCR4, 1, 1, 1, OKAY,
            1, OKAY, 1, 1, NONSEQ, INCR4, 8'h10);
    add_row("incr4_follows", 1, 8'h14, SEQ, WORD, INCR4, 1, 1, 1, OKAY,
            1, OKAY, 1, 1, SEQ, INCR4, 8'h14);
    add_row("incr4_end_idle", 1, 8'h00, IDLE, WORD, SINGLE, 1, 1, 1, OKAY,
            1, OKAY, 0, 1, IDLE, SINGLE, 8'h00);
    // WRAP4 word burst broken at offset 3
    add_row("wrap4_first", 1, 8'h28, NONSEQ, WORD, WRAP4, 1, 1, 1, OKAY,
            1, OKAY, 1, 1, NONSEQ, WRAP4, 8'h28);
    add_row("wrap4_seq_held", 1, 8'h2C, SEQ, WORD, WRAP4, 1, 0, 1, OKAY,
            1, OKAY, 1, 1, SEQ, WRAP4, 8'h2C);
    add_row("wrap4_held_out", 1, 8'h20, BUSY, WORD, WRAP4, 0, 1, 1, OKAY,
            0, OKAY, 1, 1, NONSEQ, INCR, 8'h2C);
    add_row("wrap4_busy_idle", 1, 8'h20, BUSY, WORD, WRAP4, 1, 1, 1, OKAY,
            1, OKAY, 0, 1, IDLE, INCR, 8'h20);
    add_row("wrap4_seq_ns", 1, 8'h20, SEQ, WORD, WRAP4, 1, 1, 1, OKAY,
            1, OKAY, 1, 1, NONSEQ, INCR, 8'h20);
    add_row("wrap4_seq_plain", 1, 8'h24, SEQ, WORD, WRAP4, 1, 1, 1, OKAY,
            1, OKAY, 1, 1, SEQ, INCR, 8'h24);
    add_row("wrap4_end_idle", 1, 8'h00, IDLE, WORD, SINGLE, 1, 1, 1, OKAY,
            1, OKAY, 0, 1, IDLE, INCR, 8'h00);
    // WRAP8 byte burst, offset 3 is no boundary
    add_row("wrap8_first", 1, 8'h02, NONSEQ, BYTE, WRAP8, 1, 1, 1, OKAY,
            1, OKAY, 1, 1, NONSEQ, WRAP8, 8'h02);
    add_row("wrap8_seq_held", 1, 8'h03, SEQ, BYTE, WRAP8, 1, 0, 1, OKAY,
            1, OKAY, 1, 1, SEQ, WRAP8, 8'h03);
    add_row("wrap8_held_out", 1, 8'h04, SEQ, BYTE, WRAP8, 0, 1, 1, OKAY,
            0, OKAY, 1, 1, NONSEQ, INCR, 8'h03);
    add_row("wrap8_no_rewrite", 1, 8'h04, SEQ, BYTE, WRAP8, 1, 1, 1, OKAY,
            1, OKAY, 1, 1, SEQ, INCR, 8'h04);
    add_row("wrap8_end_idle", 0, 8'h00, IDLE, BYTE, SINGLE, 1, 1, 1, OKAY,
            1, OKAY, 0, 0, IDLE, INCR, 8'h00);
    add_row("final_idle", 0, 8'h00, IDLE, BYTE, SINGLE, 1, 1, 1, OKAY,
            1, OKAY, 0, 0, IDLE, SINGLE, 8'h00);

    assert (n_rows == N_ROWS)
    else
    begin
      $display("Stimulus table holds %0d rows instead of %0d", n_rows, N_ROWS);
      $display("Test FAILED");
      $fatal(1, "Table size");
    end

    repeat (2) @(posedge HCLK);     // Reset over two edges
    HRESETn <= 1'b1;

    for (row = 0; row < N_ROWS; row++)
    begin
      apply_row(row);
      @(negedge HCLK);              // Outputs settled mid-cycle
      check_row(row);
      // Selected NONSEQ or SEQ with HREADYS high is captured
      if (t_sel[row] && t_trans[row][1] && t_rdy[row])
        last_load = row;
      @(posedge HCLK);
    end

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
logic/ahb_in_pkg.sv
logic/ahb_hold_capture.sv
logic/ahb_pend_ctrl.sv
logic/ahb_wrap_bound.sv
logic/ahb_burst_fixup.sv
logic/ahb_input_stage.sv
verif/tb_ahb_input_stage.sv
